// File: src.f
hdl/cache_data_pkg.sv
hdl/req_aligner.sv
hdl/word_bank.sv
hdl/rsp_formatter.sv
hdl/cache_data_top.sv
test/cache_data_properties.sv
test/cache_data_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache data testbench with Verilator, verdict from the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_data_tb \
    -f src.f \
    -Mdir obj_dir \
    -o cache_data_sim

./obj_dir/cache_data_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi

// File: test/cache_data_tb.sv
// testbench for the cache data store, runs a directed table, back-to-back reads and a seeded random run
`timescale 1ns/1ps
`default_nettype none

module cache_data_tb
    import cache_data_pkg::*;
();

    localparam int CL_ADRS_WIDTH = 8;
    localparam int ADRS_WIDTH    = CL_ADRS_WIDTH + OFFSET_BITS;
    localparam int MAX_ENTRIES   = 32;
    localparam int RSP_TIMEOUT   = 8;   // cycles
    localparam int RANDOM_OPS    = 200;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    t_opcode               req_opcode;
    logic [ADRS_WIDTH-1:0] req_address;
    t_word                 req_data;
    t_byte_en              req_byte_en;
    logic                  req_sign_extend;
    t_reg_id               req_reg_id;
    logic                  rsp_valid;
    logic [ADRS_WIDTH-1:0] rsp_address;
    t_word                 rsp_data;
    t_reg_id               rsp_reg_id;

    // directed table, one row per request
    string                 tbl_name [MAX_ENTRIES];
    t_opcode               tbl_op   [MAX_ENTRIES];
    logic [ADRS_WIDTH-1:0] tbl_addr [MAX_ENTRIES];
    t_word                 tbl_data [MAX_ENTRIES];
    t_byte_en              tbl_be   [MAX_ENTRIES];
    logic                  tbl_sx   [MAX_ENTRIES];
    t_word                 tbl_exp  [MAX_ENTRIES]; // read data, unused on writes
    int                    num_entries;

    logic [7:0] shadow [2**ADRS_WIDTH]; // byte image of the whole store
    int         seed;
    int         errors;
    int         tests_passed;
    int         tests_failed;

    cache_data_top #(
        .CL_ADRS_WIDTH (CL_ADRS_WIDTH)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_opcode      (req_opcode),
        .req_address     (req_address),
        .req_data        (req_data),
        .req_byte_en     (req_byte_en),
        .req_sign_extend (req_sign_extend),
        .req_reg_id      (req_reg_id),
        .rsp_valid       (rsp_valid),
        .rsp_address     (rsp_address),
        .rsp_data        (rsp_data),
        .rsp_reg_id      (rsp_reg_id)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // shadow model of the store
    // ============================================================
    task automatic model_write(input logic [ADRS_WIDTH-1:0] addr, input t_word data,
                               input t_byte_en be);
        int pos;
        for (int b = 0; b < 4; b++) begin
            pos = b + int'(addr[1:0]);
            if (be[b] && pos < 4) begin
                shadow[{addr[ADRS_WIDTH-1:2], 2'(pos)}] = data[8*b +: 8]; // past byte 3 drops
            end
        end
    endtask

    function automatic t_word model_read(input logic [ADRS_WIDTH-1:0] addr, input t_byte_en be,
                                         input logic sx);
        t_word res;
        logic  fill;
        int    pos;
        res  = '0;
        fill = 1'b0;
        for (int b = 0; b < 4; b++) begin
            pos = b + int'(addr[1:0]);
            if (be[b] && pos < 4) begin
                res[8*b +: 8] = shadow[{addr[ADRS_WIDTH-1:2], 2'(pos)}];
            end else if (!be[b] && b > 0 && sx) begin
                res[8*b +: 8] = {8{fill}}; // copies the bit just below
            end
            fill = res[8*b+7];
        end
        return res;
    endfunction

    // ============================================================
    // request driving and response checks
    // ============================================================
    task automatic put_entry(input string name, input t_opcode op,
                             input logic [ADRS_WIDTH-1:0] addr, input t_word data,
                             input t_byte_en be, input logic sx, input t_word exp);
        tbl_name[num_entries] = name;
        tbl_op[num_entries]   = op;
        tbl_addr[num_entries] = addr;
        tbl_data[num_entries] = data;
        tbl_be[num_entries]   = be;
        tbl_sx[num_entries]   = sx;
        tbl_exp[num_entries]  = exp;
        num_entries++;
    endtask

    // one-cycle strobe, called on a falling edge and returns on the next one
    task automatic send_request(input t_opcode op, input logic [ADRS_WIDTH-1:0] addr,
                                input t_word data, input t_byte_en be, input logic sx,
                                input t_reg_id id);
        req_valid       = 1'b1;
        req_opcode      = op;
        req_address     = addr;
        req_data        = data;
        req_byte_en     = be;
        req_sign_extend = sx;
        req_reg_id      = id;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic check_value(input string name, input string field, input t_word exp,
                               input t_word act, inout logic ok);
        if (act !== exp) begin
            $display("** Error %s: %s expected %h, actual %h", name, field, exp, act);
            ok = 1'b0;
            errors++;
        end
    endtask

    task automatic check_response(input string name, input logic [ADRS_WIDTH-1:0] addr,
                                  input t_reg_id id, input t_word exp, inout logic ok);
        if (!rsp_valid) begin
            $display("%s failed: read response missing when it was due", name);
            ok = 1'b0;
            errors++;
        end else begin
            check_value(name, "data", exp, rsp_data, ok);
            check_value(name, "address", 32'(addr), 32'(rsp_address), ok);
            check_value(name, "reg id", 32'(id), 32'(rsp_reg_id), ok);
        end
    endtask

    task automatic read_and_check(input string name, input logic [ADRS_WIDTH-1:0] addr,
                                  input t_byte_en be, input logic sx, input t_reg_id id,
                                  input t_word exp, inout logic ok);
        int cycles;
        send_request(RD_OP, addr, '0, be, sx, id);
        cycles = 0;
        while (!rsp_valid && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        check_response(name, addr, id, exp, ok);
    endtask

    task automatic report_test(input string name, input logic ok);
        if (ok) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    task automatic fill_table();
        // reset contents
        put_entry("rd_reset_l0",      RD_OP, 12'h000, 32'h0,        4'hF, 1'b0, 32'h00000000);
        put_entry("rd_reset_l5",      RD_OP, 12'h05C, 32'h0,        4'hF, 1'b0, 32'h00000000);
        put_entry("rd_reset_l255",    RD_OP, 12'hFF4, 32'h0,        4'hF, 1'b0, 32'h00000000);
        // full words over line 1
        put_entry("wr_l1_w0",         WR_OP, 12'h010, 32'h11111111, 4'hF, 1'b0, 32'h0);
        put_entry("wr_l1_w1",         WR_OP, 12'h014, 32'h22222222, 4'hF, 1'b0, 32'h0);
        put_entry("wr_l1_w2",         WR_OP, 12'h018, 32'h33333333, 4'hF, 1'b0, 32'h0);
        put_entry("wr_l1_w3",         WR_OP, 12'h01C, 32'h44444444, 4'hF, 1'b0, 32'h0);
        put_entry("rd_l1_w0",         RD_OP, 12'h010, 32'h0,        4'hF, 1'b0, 32'h11111111);
        put_entry("rd_l1_w1",         RD_OP, 12'h014, 32'h0,        4'hF, 1'b0, 32'h22222222);
        put_entry("rd_l1_w2",         RD_OP, 12'h018, 32'h0,        4'hF, 1'b0, 32'h33333333);
        put_entry("rd_l1_w3",         RD_OP, 12'h01C, 32'h0,        4'hF, 1'b0, 32'h44444444);
        put_entry("wr_l1_w2_new",     WR_OP, 12'h018, 32'hCAFEF00D, 4'hF, 1'b0, 32'h0);
        put_entry("rd_l1_w2_new",     RD_OP, 12'h018, 32'h0,        4'hF, 1'b0, 32'hCAFEF00D);
        put_entry("rd_l1_w1_kept",    RD_OP, 12'h014, 32'h0,        4'hF, 1'b0, 32'h22222222);
        put_entry("rd_l1_w3_kept",    RD_OP, 12'h01C, 32'h0,        4'hF, 1'b0, 32'h44444444);
        // partial writes merged into line 2 word 0
        put_entry("wr_l2_full",       WR_OP, 12'h020, 32'hA1B2C3D4, 4'hF, 1'b0, 32'h0);
        put_entry("wr_l2_byte_bo2",   WR_OP, 12'h022, 32'h000000EE, 4'h1, 1'b0, 32'h0);
        put_entry("rd_l2_byte",       RD_OP, 12'h020, 32'h0,        4'hF, 1'b0, 32'hA1EEC3D4);
        put_entry("wr_l2_half_bo1",   WR_OP, 12'h021, 32'h00005566, 4'h3, 1'b0, 32'h0);
        put_entry("rd_l2_half",       RD_OP, 12'h020, 32'h0,        4'hF, 1'b0, 32'hA15566D4);
        put_entry("wr_l2_drop_bo3",   WR_OP, 12'h023, 32'h00007788, 4'h3, 1'b0, 32'h0);
        put_entry("rd_l2_drop",       RD_OP, 12'h020, 32'h0,        4'hF, 1'b0, 32'h885566D4);
        // offset reads from line 3 word 0
        put_entry("wr_l3_full",       WR_OP, 12'h030, 32'h7F80C3A5, 4'hF, 1'b0, 32'h0);
        put_entry("rd_bo1_byte_zero", RD_OP, 12'h031, 32'h0,        4'h1, 1'b0, 32'h000000C3);
        put_entry("rd_bo1_byte_sext", RD_OP, 12'h031, 32'h0,        4'h1, 1'b1, 32'hFFFFFFC3);
        put_entry("rd_bo1_half_zero", RD_OP, 12'h031, 32'h0,        4'h3, 1'b0, 32'h000080C3);
        put_entry("rd_bo1_half_sext", RD_OP, 12'h031, 32'h0,        4'h3, 1'b1, 32'hFFFF80C3);
        put_entry("rd_bo2_byte_sext", RD_OP, 12'h032, 32'h0,        4'h1, 1'b1, 32'hFFFFFF80);
        put_entry("rd_bo2_half_pos",  RD_OP, 12'h032, 32'h0,        4'h3, 1'b1, 32'h00007F80);
        put_entry("rd_bo3_byte_pos",  RD_OP, 12'h033, 32'h0,        4'h1, 1'b1, 32'h0000007F);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        logic                  ok;
        logic [ADRS_WIDTH-1:0] addr;
        t_word                 data;
        t_byte_en              be;
        logic                  sx;
        seed            = 91331;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        num_entries     = 0;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req_opcode      = RD_OP;
        req_address     = '0;
        req_data        = '0;
        req_byte_en     = '0;
        req_sign_extend = 1'b0;
        req_reg_id      = '0;
        for (int a = 0; a < 2**ADRS_WIDTH; a++) begin
            shadow[a] = 8'h0;
        end
        fill_table();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < num_entries; i++) begin
            ok = 1'b1;
            if (tbl_op[i] == WR_OP) begin
                send_request(WR_OP, tbl_addr[i], tbl_data[i], tbl_be[i], tbl_sx[i], 5'(i));
                model_write(tbl_addr[i], tbl_data[i], tbl_be[i]);
            end else begin
                read_and_check(tbl_name[i], tbl_addr[i], tbl_be[i], tbl_sx[i], 5'(i),
                               tbl_exp[i], ok);
            end
            report_test(tbl_name[i], ok);
        end

        // reads in consecutive cycles, each answer due exactly one cycle later
        ok = 1'b1;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            addr = {8'd1, 2'(i), 2'b00};
            send_request(RD_OP, addr, '0, 4'hF, 1'b0, 5'(20 + i));
            check_response("read_burst", addr, 5'(20 + i), model_read(addr, 4'hF, 1'b0), ok);
        end
        report_test("read_burst", ok);

        ok = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = {6'd0, 2'($random(seed)), 4'($random(seed))}; // lines 0 to 3
            data = $random(seed);
            be   = 4'($random(seed));
            sx   = 1'($random(seed));
            if (1'($random(seed))) begin
                send_request(WR_OP, addr, data, be, sx, 5'(n));
                model_write(addr, data, be);
            end else begin
                read_and_check($sformatf("random_%0d", n), addr, be, sx, 5'(n),
                               model_read(addr, be, sx), ok);
            end
        end
        report_test("random_sequence", ok);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/cache_data_properties.sv
// response timing assertions for the cache data top, attached to it with bind
`timescale 1ns/1ps
`default_nettype none

module cache_data_properties (
    input logic clk,
    input logic rst,
    input logic rd_strobe,
    input logic rsp_valid
);

    // ============================================================
    // response timing
    // ============================================================
    // low from the second reset cycle through the first cycle after reset
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high during reset or right after it");

    a_read_answered: assert property (@(posedge clk) disable iff (rst)
        rd_strobe |=> rsp_valid)
        else $error("read strobe without rsp_valid one cycle later");

    // every response needs a read in the cycle before
    a_no_spurious_rsp: assert property (@(posedge clk) disable iff (rst)
        !rd_strobe |=> !rsp_valid)
        else $error("rsp_valid without a read strobe in the previous cycle");

endmodule

bind cache_data_top cache_data_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .rd_strobe (rd_strobe),
    .rsp_valid (rsp_valid)
);

`default_nettype wire

// File: hdl/cache_data_top.sv
// top of the cache data store, ties request aligner, four word banks and response formatter together
`timescale 1ns/1ps
`default_nettype none

module cache_data_top
    import cache_data_pkg::*;
#(
    parameter int CL_ADRS_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    // core request, single-cycle strobe
    input  logic                                 req_valid,
    input  t_opcode                              req_opcode,
    input  logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] req_address,
    input  t_word                                req_data,
    input  t_byte_en                             req_byte_en,
    input  logic                                 req_sign_extend,
    input  t_reg_id                              req_reg_id,
    // read response, one clock after the request
    output logic                                 rsp_valid,
    output logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] rsp_address,
    output t_word                                rsp_data,
    output t_reg_id                              rsp_reg_id
);

    // aligner to banks
    logic [CL_ADRS_WIDTH-1:0]             line_address;
    logic [WORDS_PER_LINE-1:0]            bank_wr;
    t_word                                wr_data;
    t_byte_en                             wr_byte_en;

    // aligner to formatter
    logic                                 rd_strobe;
    t_word_offset                         word_offset;
    t_byte_offset                         byte_offset;
    t_byte_en                             rd_byte_en;
    logic                                 rd_sign_extend;
    t_reg_id                              rd_reg_id;
    logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] rd_address;

    // banks to formatter
    t_word [WORDS_PER_LINE-1:0]           bank_rd_data;

    // ============================================================
    // request side
    // ============================================================
    req_aligner #(
        .CL_ADRS_WIDTH (CL_ADRS_WIDTH)
    ) u_req_aligner (
        .req_valid       (req_valid),
        .req_opcode      (req_opcode),
        .req_address     (req_address),
        .req_data        (req_data),
        .req_byte_en     (req_byte_en),
        .req_sign_extend (req_sign_extend),
        .req_reg_id      (req_reg_id),
        .line_address    (line_address),
        .word_offset     (word_offset),
        .byte_offset     (byte_offset),
        .bank_wr         (bank_wr),
        .wr_data         (wr_data),
        .wr_byte_en      (wr_byte_en),
        .rd_strobe       (rd_strobe),
        .rd_byte_en      (rd_byte_en),
        .rd_sign_extend  (rd_sign_extend),
        .rd_reg_id       (rd_reg_id),
        .rd_address      (rd_address)
    );

    // ============================================================
    // word banks, one per word offset
    // ============================================================
    for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : g_bank
        word_bank #(
            .CL_ADRS_WIDTH (CL_ADRS_WIDTH)
        ) u_word_bank (
            .clk          (clk),
            .rst          (rst),
            .wr           (bank_wr[i]),
            .line_address (line_address),
            .wr_data      (wr_data),
            .wr_byte_en   (wr_byte_en),
            .rd_data      (bank_rd_data[i])
        );
    end

    // ============================================================
    // response side
    // ============================================================
    rsp_formatter #(
        .CL_ADRS_WIDTH (CL_ADRS_WIDTH)
    ) u_rsp_formatter (
        .clk            (clk),
        .rst            (rst),
        .rd_strobe      (rd_strobe),
        .word_offset    (word_offset),
        .byte_offset    (byte_offset),
        .bank_rd_data   (bank_rd_data),
        .rd_byte_en     (rd_byte_en),
        .rd_sign_extend (rd_sign_extend),
        .rd_reg_id      (rd_reg_id),
        .rd_address     (rd_address),
        .rsp_valid      (rsp_valid),
        .rsp_address    (rsp_address),
        .rsp_data       (rsp_data),
        .rsp_reg_id     (rsp_reg_id)
    );

endmodule

`default_nettype wire

// File: hdl/rsp_formatter.sv
// picks the addressed bank word, shifts, masks and sign-extends it, then registers the read response
`timescale 1ns/1ps
`default_nettype none

module rsp_formatter
    import cache_data_pkg::*;
#(
    parameter int CL_ADRS_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    // read request, same cycle as the bank read
    input  logic                                 rd_strobe,
    input  t_word_offset                         word_offset,
    input  t_byte_offset                         byte_offset,
    input  t_word [WORDS_PER_LINE-1:0]           bank_rd_data, // lane 0 lowest
    input  t_byte_en                             rd_byte_en,
    input  logic                                 rd_sign_extend,
    input  t_reg_id                              rd_reg_id,
    input  logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] rd_address,
    // core response
    output logic                                 rsp_valid,
    output logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] rsp_address,
    output t_word                                rsp_data,
    output t_reg_id                              rsp_reg_id
);

    t_word sel_word;     // word of the addressed bank
    t_word shifted_word; // after the down shift
    t_word rd_word;      // masked and extended

    // ============================================================
    // word select and alignment
    // ============================================================
    assign sel_word = bank_rd_data[word_offset];

    // zero fill from the top
    always_comb begin
        case (byte_offset)
            2'd1:    shifted_word = {8'h0, sel_word[31:8]};
            2'd2:    shifted_word = {16'h0, sel_word[31:16]};
            2'd3:    shifted_word = {24'h0, sel_word[31:24]};
            default: shifted_word = sel_word;
        endcase
    end

    // ============================================================
    // byte mask and sign extension
    // ============================================================
    // a cleared byte copies the bit right below it when extending,
    // so the top bit of the highest enabled byte spreads upward
    always_comb begin
        logic top_bit;
        top_bit = 1'b0;
        rd_word = '0;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (rd_byte_en[b]) begin
                rd_word[8*b +: 8] = shifted_word[8*b +: 8];
            end else if ((b > 0) && rd_sign_extend) begin
                rd_word[8*b +: 8] = {8{top_bit}};
            end else begin
                rd_word[8*b +: 8] = 8'h0; // byte 0 never extends
            end
            top_bit = rd_word[8*b+7];
        end
    end

    // ============================================================
    // response register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_strobe; // exactly one cycle after the request
        end
    end

    // payload held between responses
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rsp_address <= rd_address;
            rsp_data    <= rd_word;
            rsp_reg_id  <= rd_reg_id;
        end
    end

endmodule

`default_nettype wire

// File: hdl/word_bank.sv
// one word lane of every cache line, byte-enabled synchronous write and combinational read
`timescale 1ns/1ps
`default_nettype none

module word_bank
    import cache_data_pkg::*;
#(
    parameter int CL_ADRS_WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr,
    input  logic [CL_ADRS_WIDTH-1:0] line_address,
    input  t_word                    wr_data,
    input  t_byte_en                 wr_byte_en,
    output t_word                    rd_data
);

    localparam int NUM_LINES = 2**CL_ADRS_WIDTH;

    t_word mem [NUM_LINES];

    // ============================================================
    // storage
    // ============================================================
    // whole array clears on reset, the data store starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int line = 0; line < NUM_LINES; line++) begin
                mem[line] <= '0;
            end
        end else if (wr) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (wr_byte_en[b]) begin
                    mem[line_address][8*b +: 8] <= wr_data[8*b +: 8]; // enabled byte only
                end
            end
        end
    end

    // ============================================================
    // read port
    // ============================================================
    assign rd_data = mem[line_address]; // async, addressed entry always shown

endmodule

`default_nettype wire

// File: hdl/req_aligner.sv
// splits a core request into line and offsets, aligns write data and drives bank write strobes
`timescale 1ns/1ps
`default_nettype none

module req_aligner
    import cache_data_pkg::*;
#(
    parameter int CL_ADRS_WIDTH = 8
) (
    // core request
    input  logic                                 req_valid,
    input  t_opcode                              req_opcode,
    input  logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] req_address,
    input  t_word                                req_data,
    input  t_byte_en                             req_byte_en,
    input  logic                                 req_sign_extend,
    input  t_reg_id                              req_reg_id,
    // toward the banks
    output logic [CL_ADRS_WIDTH-1:0]             line_address,
    output t_word_offset                         word_offset,
    output t_byte_offset                         byte_offset,
    output logic [WORDS_PER_LINE-1:0]            bank_wr,
    output t_word                                wr_data,
    output t_byte_en                             wr_byte_en,
    // toward the formatter
    output logic                                 rd_strobe,
    output t_byte_en                             rd_byte_en,
    output logic                                 rd_sign_extend,
    output t_reg_id                              rd_reg_id,
    output logic [CL_ADRS_WIDTH+OFFSET_BITS-1:0] rd_address
);

    localparam int ADRS_WIDTH = CL_ADRS_WIDTH + OFFSET_BITS;

    logic wr_req;

    // ============================================================
    // address split
    // ============================================================
    assign line_address = req_address[ADRS_WIDTH-1:OFFSET_BITS];
    assign word_offset  = req_address[WORD_OFFSET_MSB:WORD_OFFSET_LSB];
    assign byte_offset  = req_address[BYTE_OFFSET_MSB:BYTE_OFFSET_LSB];

    // ============================================================
    // write alignment
    // ============================================================
    // data and enables move up by the byte offset,
    // enables pushed past byte 3 fall off the word
    always_comb begin
        case (byte_offset)
            2'd1: begin
                wr_data    = {req_data[23:0], 8'h0};
                wr_byte_en = {req_byte_en[2:0], 1'b0};
            end
            2'd2: begin
                wr_data    = {req_data[15:0], 16'h0};
                wr_byte_en = {req_byte_en[1:0], 2'b0};
            end
            2'd3: begin
                wr_data    = {req_data[7:0], 24'h0};
                wr_byte_en = {req_byte_en[0], 3'b0};
            end
            default: begin
                wr_data    = req_data;
                wr_byte_en = req_byte_en;
            end
        endcase
    end

    assign wr_req = req_valid && (req_opcode == WR_OP);

    // one bank per word offset, only the addressed one writes
    always_comb begin
        bank_wr = '0;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            if (wr_req && (word_offset == t_word_offset'(i))) begin
                bank_wr[i] = 1'b1;
            end
        end
    end

    // ============================================================
    // read side, passed on unregistered
    // ============================================================
    assign rd_strobe      = req_valid && (req_opcode == RD_OP);
    assign rd_byte_en     = req_byte_en;     // not shifted, applies to the result
    assign rd_sign_extend = req_sign_extend;
    assign rd_reg_id      = req_reg_id;
    assign rd_address     = req_address;     // echoed on the response

endmodule

`default_nettype wire

// File: hdl/cache_data_pkg.sv
// shared word, enable, register id and opcode types plus line layout, imported by every design file
`default_nettype none

package cache_data_pkg;

    // ============================================================
    // core interface types
    // ============================================================
    typedef logic [31:0] t_word;    // one data word
    typedef logic [3:0]  t_byte_en; // one enable per byte of a word
    typedef logic [4:0]  t_reg_id;  // destination register, echoed on read
    typedef logic [1:0]  t_opcode;

    localparam t_opcode RD_OP = 2'd0;
    localparam t_opcode WR_OP = 2'd1;

    // ============================================================
    // line layout
    // ============================================================
    localparam int WORDS_PER_LINE = 4;  // also the number of banks
    localparam int BYTES_PER_WORD = 4;
    localparam int OFFSET_BITS    = 4;  // address bits below the line address

    // offset fields inside the low address bits
    localparam int WORD_OFFSET_MSB = 3;
    localparam int WORD_OFFSET_LSB = 2;
    localparam int BYTE_OFFSET_MSB = 1;
    localparam int BYTE_OFFSET_LSB = 0;

    typedef logic [WORD_OFFSET_MSB-WORD_OFFSET_LSB:0] t_word_offset;
    typedef logic [BYTE_OFFSET_MSB-BYTE_OFFSET_LSB:0] t_byte_offset;

endpackage

`default_nettype wire
